/* logic/aes_key_cfg.svh */
`ifndef AES_KEY_CFG_SVH
`define AES_KEY_CFG_SVH

// AES-128 has ten rounds, so eleven round keys
`define AES_ROUND 10

`define AES_KEY_W 128

`define AES_WORD_W 32

`endif

/* logic/aes_key_pkg.sv */
`include "aes_key_cfg.svh"

package aes_key_pkg;

    typedef logic [`AES_WORD_W-1:0] aes_word_t;

    // word 0 sits in the most significant bits
    typedef logic [`AES_KEY_W-1:0] aes_key_t;

    // round index, 0 to 10
    typedef logic [3:0] round_idx_t;

    // controller command to counter and expansion step
    typedef struct packed {
        logic load;
        logic update;
    } step_cmd_t;

    typedef struct packed {
        round_idx_t round;
        logic [7:0] rcon;
    } round_state_t;

    // one write into the round key memory
    typedef struct packed {
        logic       we;
        round_idx_t addr;
        aes_key_t   data;
    } key_wr_t;

endpackage

/* logic/aes_sbox_word.sv */
`timescale 1ns/1ps

module aes_sbox_word import aes_key_pkg::*; (
    input  aes_word_t word_i,
    output aes_word_t word_o
);

    // multiply by x in GF(2^8), reduction polynomial 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (8'h1b & {8{a[7]}});
    endfunction

    // shift-and-add field multiply
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // inverse as a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] res;
        logic [7:0] sq;
        res = 8'h01;
        sq  = a;
        // 254 = 2 + 4 + ... + 128
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            res = gf_mul(res, sq);
        end
        return res;
    endfunction

    // affine map over GF(2) with constant 0x63
    function automatic logic [7:0] affine(input logic [7:0] b);
        logic [7:0] r1;
        logic [7:0] r2;
        logic [7:0] r3;
        logic [7:0] r4;
        r1 = {b[6:0], b[7]};
        r2 = {b[5:0], b[7:6]};
        r3 = {b[4:0], b[7:5]};
        r4 = {b[3:0], b[7:4]};
        return b ^ r1 ^ r2 ^ r3 ^ r4 ^ 8'h63;
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] a);
        return affine(gf_inv(a));
    endfunction

    // four byte lanes in parallel
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            word_o[n*8 +: 8] = sbox(word_i[n*8 +: 8]);
        end
    end

endmodule

/* logic/key_sched_ctrl.sv */
`timescale 1ns/1ps
`include "aes_key_cfg.svh"

module key_sched_ctrl import aes_key_pkg::*; (
    input  logic         clk_i,
    input  logic         round_ctr_rst,
    input  logic         init_i,
    input  round_state_t rstate_i,
    output step_cmd_t    cmd_o,
    output logic         ready_o
);

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_INIT,
        CTRL_GENERATE,
        CTRL_DONE
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        ready_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (init_i) begin
                    state_d = CTRL_INIT;
                end
            end
            CTRL_INIT: begin
                state_d = CTRL_GENERATE;
            end
            CTRL_GENERATE: begin
                // last key is written in the cycle of round 10
                if (rstate_i.round == 4'(`AES_ROUND)) begin
                    state_d = CTRL_DONE;
                end
            end
            CTRL_DONE: begin
                state_d = CTRL_IDLE;
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (round_ctr_rst) begin
            state_q <= CTRL_IDLE;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == CTRL_IDLE && init_i) begin
                ready_q <= 1'b0;
            end else if (state_q == CTRL_DONE) begin
                ready_q <= 1'b1;
            end
        end
    end

    assign cmd_o.load   = (state_q == CTRL_INIT);
    assign cmd_o.update = (state_q == CTRL_GENERATE);
    assign ready_o      = ready_q;

endmodule

/* logic/round_rcon_counter.sv */
`timescale 1ns/1ps

module round_rcon_counter import aes_key_pkg::*; (
    input  logic         clk_i,
    input  logic         round_ctr_rst,
    input  step_cmd_t    cmd_i,
    output round_state_t rstate_o
);

    round_idx_t round_q;
    logic [7:0] rcon_q;
    logic [7:0] rcon_dbl;

    // doubling in GF(2^8)
    assign rcon_dbl = {rcon_q[6:0], 1'b0} ^ (8'h1b & {8{rcon_q[7]}});

    always_ff @(posedge clk_i) begin
        if (round_ctr_rst) begin
            round_q <= '0;
            rcon_q  <= 8'h00;
        end else if (cmd_i.load) begin
            // 0x8d doubles to 0x01, the constant of round 1
            round_q <= '0;
            rcon_q  <= 8'h8d;
        end else if (cmd_i.update) begin
            round_q <= round_q + 4'd1;
            rcon_q  <= rcon_dbl;
        end
    end

    assign rstate_o.round = round_q;
    assign rstate_o.rcon  = rcon_q;

endmodule

/* logic/key_expand_step.sv */
`timescale 1ns/1ps

module key_expand_step import aes_key_pkg::*; (
    input  logic         clk_i,
    input  logic         round_ctr_rst,
    input  step_cmd_t    cmd_i,
    input  round_state_t rstate_i,
    input  aes_key_t     key_i,
    output aes_word_t    sbox_word_o,
    input  aes_word_t    sbox_word_i,
    output key_wr_t      wr_o
);

    aes_key_t  prev_key_q;
    aes_key_t  next_key;
    aes_word_t w0;
    aes_word_t w1;
    aes_word_t w2;
    aes_word_t w3;
    aes_word_t k0;
    aes_word_t k1;
    aes_word_t k2;
    aes_word_t k3;
    aes_word_t trw;

    assign w0 = prev_key_q[127:96];
    assign w1 = prev_key_q[95:64];
    assign w2 = prev_key_q[63:32];
    assign w3 = prev_key_q[31:0];

    // last word goes through the S-box
    assign sbox_word_o = w3;

    // rotate the substituted word, then add the round constant
    assign trw = {sbox_word_i[23:0], sbox_word_i[31:24]} ^ {rstate_i.rcon, 24'h000000};

    assign k0 = w0 ^ trw;
    assign k1 = w1 ^ k0;
    assign k2 = w2 ^ k1;
    assign k3 = w3 ^ k2;

    // round 0 stores the cipher key itself
    assign next_key = (rstate_i.round == 4'd0) ? key_i : {k0, k1, k2, k3};

    always_ff @(posedge clk_i) begin
        if (round_ctr_rst) begin
            prev_key_q <= '0;
        end else if (cmd_i.update) begin
            prev_key_q <= next_key;
        end
    end

    assign wr_o.we   = cmd_i.update;
    assign wr_o.addr = rstate_i.round;
    assign wr_o.data = next_key;

endmodule

/* logic/round_key_store.sv */
`timescale 1ns/1ps
`include "aes_key_cfg.svh"

module round_key_store import aes_key_pkg::*; (
    input  logic       clk_i,
    input  logic       round_ctr_rst,
    input  key_wr_t    wr_i,
    input  round_idx_t round_i,
    output aes_key_t   round_key_o
);

    aes_key_t key_mem [0:`AES_ROUND];

    always_ff @(posedge clk_i) begin
        if (round_ctr_rst) begin
            for (int i = 0; i <= `AES_ROUND; i++) begin
                key_mem[i] <= '0;
            end
        end else if (wr_i.we) begin
            key_mem[wr_i.addr] <= wr_i.data;
        end
    end

    // indexes past round 10 read as zero
    always_comb begin
        if (round_i <= 4'(`AES_ROUND)) begin
            round_key_o = key_mem[round_i];
        end else begin
            round_key_o = '0;
        end
    end

endmodule

/* logic/aes_key_sched_top.sv */
`timescale 1ns/1ps

module aes_key_sched_top import aes_key_pkg::*; (
    input  logic       clk_i,
    input  logic       round_ctr_rst,
    input  aes_key_t   key_i,
    input  logic       init_i,
    input  round_idx_t round_i,
    output aes_key_t   round_key_o,
    output logic       ready_o
);

    step_cmd_t    cmd;
    round_state_t rstate;
    aes_word_t    sbox_word;
    aes_word_t    sbox_result;
    key_wr_t      wr;

    key_sched_ctrl key_sched_ctrl_inst (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .init_i        (init_i),
        .rstate_i      (rstate),
        .cmd_o         (cmd),
        .ready_o       (ready_o)
    );

    round_rcon_counter round_rcon_counter_inst (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .cmd_i         (cmd),
        .rstate_o      (rstate)
    );

    key_expand_step key_expand_step_inst (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .cmd_i         (cmd),
        .rstate_i      (rstate),
        .key_i         (key_i),
        .sbox_word_o   (sbox_word),
        .sbox_word_i   (sbox_result),
        .wr_o          (wr)
    );

    aes_sbox_word aes_sbox_word_inst (
        .word_i (sbox_word),
        .word_o (sbox_result)
    );

    round_key_store round_key_store_inst (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .wr_i          (wr),
        .round_i       (round_i),
        .round_key_o   (round_key_o)
    );

endmodule

/* testbench/tb_aes_key_sched.sv */
`timescale 1ns/1ps
`include "aes_key_cfg.svh"

module tb_aes_key_sched import aes_key_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RAND   = 8;
    // FIPS key, the stray-init run and the random keys
    localparam int NUM_RUNS   = NUM_RAND + 2;
    // one run is about 26 cycles of generation and readback
    localparam int RUN_CYCLES = 40;
    localparam int WATCHDOG_CYCLES = (NUM_RUNS + 2) * RUN_CYCLES;
    localparam aes_key_t FIPS_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_key_t FIPS_R10 = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;

    logic       clk_i;
    logic       round_ctr_rst;
    logic       init_i;
    aes_key_t   key_i;
    round_idx_t round_i;
    aes_key_t   round_key_o;
    logic       ready_o;

    logic [31:0] lfsr_q = 32'h3875_b398;
    int          value_errs = 0;
    int          other_errs = 0;
    aes_key_t    exp_keys [0:`AES_ROUND];
    aes_key_t    first_key;
    aes_key_t    stray_key;

    aes_key_sched_top aes_key_sched_top_inst (
        .clk_i         (clk_i),
        .round_ctr_rst (round_ctr_rst),
        .key_i         (key_i),
        .init_i        (init_i),
        .round_i       (round_i),
        .round_key_o   (round_key_o),
        .ready_o       (ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // ready only drops on an init strobe
    assert property (@(posedge clk_i) disable iff (round_ctr_rst)
                     (ready_o && !init_i) |=> ready_o)
    else begin
        other_errs++;
        $display("ready_o dropped although init_i was low");
    end

    assert property (@(posedge clk_i) disable iff (round_ctr_rst)
                     $fell(ready_o) |-> $past(init_i))
    else begin
        other_errs++;
        $display("ready_o fell on an edge that did not follow an init_i strobe");
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic aes_key_t rand_key();
        aes_key_t k;
        k = '0;
        for (int i = 0; i < 128; i++) begin
            k = {k[126:0], lfsr_bit()};
        end
        return k;
    endfunction

    // reference field math by peasant multiply and inverse search
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        logic [7:0] y;
        logic       hi;
        p = 8'h00;
        x = a;
        y = b;
        for (int i = 0; i < 8; i++) begin
            if (y[0]) begin
                p = p ^ x;
            end
            hi = x[7];
            x  = {x[6:0], 1'b0};
            if (hi) begin
                x = x ^ 8'h1b;
            end
            y = {1'b0, y[7:1]};
        end
        return p;
    endfunction

    function automatic logic [7:0] ginv(input logic [7:0] a);
        if (a == 8'h00) begin
            return 8'h00;
        end
        for (int c = 1; c < 256; c++) begin
            if (gmul(a, 8'(c)) == 8'h01) begin
                return 8'(c);
            end
        end
        return 8'h00;
    endfunction

    function automatic logic [7:0] sbox_ref(input logic [7:0] a);
        logic [7:0] v;
        logic [7:0] s;
        v = ginv(a);
        for (int i = 0; i < 8; i++) begin
            s[i] = v[i] ^ v[(i + 4) % 8] ^ v[(i + 5) % 8] ^ v[(i + 6) % 8]
                 ^ v[(i + 7) % 8];
        end
        return s ^ 8'h63;
    endfunction

    // FIPS-197 expansion into exp_keys
    task automatic compute_schedule(input aes_key_t key);
        logic [31:0] w [0:43];
        logic [31:0] t;
        logic [7:0]  rc;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = key[127 - 32 * i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
            t = w[i - 1];
            if (i % 4 == 0) begin
                t = {sbox_ref(t[23:16]), sbox_ref(t[15:8]), sbox_ref(t[7:0]),
                     sbox_ref(t[31:24])} ^ {rc, 24'h000000};
                rc = gmul(rc, 8'h02);
            end
            w[i] = w[i - 4] ^ t;
        end
        for (int r = 0; r <= `AES_ROUND; r++) begin
            exp_keys[r] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
        end
    endtask

    // read every entry, optionally in a shuffled order
    task automatic check_store(input bit shuffle);
        int start;
        int stride;
        int idx;
        start  = 0;
        stride = 1;
        if (shuffle) begin
            start  = int'(rand_bits(4)) % (`AES_ROUND + 1);
            stride = 1 + int'(rand_bits(4)) % `AES_ROUND;
        end
        for (int k = 0; k <= `AES_ROUND; k++) begin
            idx = (start + k * stride) % (`AES_ROUND + 1);
            @(negedge clk_i);
            round_i = round_idx_t'(idx);
            #10;
            assert (round_key_o === exp_keys[idx])
            else begin
                value_errs++;
                $display("error: round_key_o round %0h expected %h actual %h",
                         idx, exp_keys[idx], round_key_o);
            end
        end
    endtask

    // one init strobe, then wait for ready with a cycle limit
    task automatic run_keygen(input aes_key_t key, input bit stray, input aes_key_t other);
        int cycles;
        compute_schedule(key);
        @(negedge clk_i);
        key_i  = key;
        init_i = 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        init_i = 1'b0;
        assert (ready_o === 1'b0)
        else begin
            value_errs++;
            $display("error: ready_o after init expected 0 actual %h", ready_o);
        end
        cycles = 0;
        while (ready_o !== 1'b1 && cycles < 30) begin
            @(negedge clk_i);
            cycles++;
            // new key and strobe well after round 0 was taken
            if (stray && cycles == 4) begin
                key_i  = other;
                init_i = 1'b1;
            end else begin
                init_i = 1'b0;
            end
        end
        init_i = 1'b0;
        if (ready_o !== 1'b1) begin
            other_errs++;
            $display("ready_o never rose within 30 cycles of an accepted init_i");
        end else begin
            assert (cycles == 13)
            else begin
                value_errs++;
                $display("error: ready_o rise cycle expected %0h actual %0h", 13, cycles);
            end
        end
    endtask

    initial begin
        round_ctr_rst = 1'b1;
        init_i        = 1'b0;
        key_i         = '0;
        round_i       = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        round_ctr_rst = 1'b0;

        assert (ready_o === 1'b0)
        else begin
            value_errs++;
            $display("error: ready_o after reset expected 0 actual %h", ready_o);
        end
        for (int r = 0; r <= `AES_ROUND; r++) begin
            exp_keys[r] = '0;
        end
        check_store(1'b0);

        run_keygen(FIPS_KEY, 1'b0, '0);
        assert (exp_keys[`AES_ROUND] == FIPS_R10)
        else begin
            other_errs++;
            $display("reference model does not reproduce the FIPS-197 round 10 key");
        end
        check_store(1'b0);

        // init during generation with another key must leave no trace
        first_key = rand_key();
        stray_key = rand_key();
        run_keygen(first_key, 1'b1, stray_key);
        check_store(1'b1);

        for (int n = 0; n < NUM_RAND; n++) begin
            run_keygen(rand_key(), 1'b0, '0);
            check_store(1'b1);
        end

        repeat (3) begin
            @(negedge clk_i);
            key_i = rand_key();
        end
        assert (ready_o === 1'b1)
        else begin
            value_errs++;
            $display("error: ready_o while idle expected 1 actual %h", ready_o);
        end
        check_store(1'b1);

        @(negedge clk_i);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/aes_key_pkg.sv
logic/aes_sbox_word.sv
logic/key_sched_ctrl.sv
logic/round_rcon_counter.sv
logic/key_expand_step.sv
logic/round_key_store.sv
logic/aes_key_sched_top.sv
testbench/tb_aes_key_sched.sv

/* Makefile */
TOP = tb_aes_key_sched

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
